// ==== i2c_guard_top.f ====
hdl/i2c_guard_pkg.sv
hdl/i2c_line_sampler.sv
hdl/i2c_bit_counter.sv
hdl/i2c_frame_fsm.sv
hdl/i2c_byte_shifter.sv
hdl/i2c_parity_check.sv
hdl/i2c_cmd_filter.sv
hdl/i2c_guard_top.sv
verif/tb_i2c_guard_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the i2c guard testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_i2c_guard_top -f i2c_guard_top.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

// ==== verif/tb_i2c_guard_top.sv ====
// directed testbench for the i2c guard: bus driver tasks, checks, lfsr stimulus and watchdog
`default_nettype none

module tb_i2c_guard_top;

    timeunit 1ns;
    timeprecision 1ps;

    import i2c_guard_pkg::*;

    localparam int clk_period_ns = 40;
    localparam int half_cycles   = 8;
    // six tests, at most 40 units of 18 half periods each
    localparam int run_budget_ns = 6 * 40 * 18 * half_cycles * clk_period_ns;
    localparam int watchdog_ns   = run_budget_ns + 200000;

    logic  clk = 1'b0;
    logic  rst_sync_n;
    logic  scl;
    logic  sda;
    logic  byte_strobe;
    byte_t rx_byte;
    logic  parity_error;
    logic  cmd_blocked;

    byte_t       captured[$];
    byte_t       expected[$];
    logic [31:0] lfsr_state;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    always #(clk_period_ns / 2) clk = ~clk;

    i2c_guard_top u_i2c_guard_top (
        .clk          (clk),
        .rst_sync_n   (rst_sync_n),
        .scl          (scl),
        .sda          (sda),
        .byte_strobe  (byte_strobe),
        .rx_byte      (rx_byte),
        .parity_error (parity_error),
        .cmd_blocked  (cmd_blocked)
    );

    // strobes sampled mid-cycle
    always @(negedge clk) begin
        if (rst_sync_n && byte_strobe) begin
            captured.push_back(rx_byte);
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the bus tests never completed", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    // ninth bit that makes the unit even
    function automatic logic even_parity(input byte_t b);
        return ^b;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // sda moves early in the low half, scl high for a full half
    task automatic send_bit(input logic b);
        wait_cycles(2);
        sda = b;
        wait_cycles(half_cycles - 2);
        scl = 1'b1;
        wait_cycles(half_cycles);
        scl = 1'b0;
    endtask

    task automatic send_start();
        wait_cycles(2);
        sda = 1'b1;
        wait_cycles(half_cycles - 2);
        scl = 1'b1;
        wait_cycles(half_cycles);
        sda = 1'b0;
        wait_cycles(half_cycles);
        scl = 1'b0;
    endtask

    task automatic send_stop();
        wait_cycles(2);
        sda = 1'b0;
        wait_cycles(half_cycles - 2);
        scl = 1'b1;
        wait_cycles(half_cycles);
        sda = 1'b1;
        wait_cycles(half_cycles);
    endtask

    task automatic send_unit(input byte_t data, input logic ninth);
        for (int i = 7; i >= 0; i--) begin
            send_bit(data[i]);
        end
        send_bit(ninth);
    endtask

    task automatic send_frame(input byte_t cmd, input logic ninth);
        send_start();
        send_unit(cmd, ninth);
        send_stop();
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL @ %0d ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic expect_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_fail($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic compare_captured();
        if (captured.size() != expected.size()) begin
            report_fail($sformatf("captured %0d bytes, expected %0d",
                                  captured.size(), expected.size()));
        end else begin
            foreach (expected[i]) begin
                if (captured[i] !== expected[i]) begin
                    report_fail($sformatf("byte %0d is %h, expected %h",
                                          i, captured[i], expected[i]));
                end
            end
        end
    endtask

    task automatic start_test();
        captured.delete();
        expected.delete();
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
    endtask

    task automatic test_good_parity();
        start_test();
        expect_level("parity_error after reset", parity_error, 1'b0);
        expect_level("cmd_blocked after reset", cmd_blocked, 1'b0);
        send_frame(8'hA0, even_parity(8'hA0));
        wait_cycles(20);
        expected.push_back(8'hA0);
        compare_captured();
        expect_level("parity_error", parity_error, 1'b0);
        expect_level("cmd_blocked", cmd_blocked, 1'b0);
        finish_test("correct parity");
    endtask

    task automatic test_bad_parity();
        start_test();
        send_frame(8'hA0, ~even_parity(8'hA0));
        wait_cycles(20);
        expected.push_back(8'hA0);
        compare_captured();
        expect_level("parity_error", parity_error, 1'b1);
        expect_level("cmd_blocked", cmd_blocked, 1'b0);
        finish_test("wrong parity");
    endtask

    task automatic test_whitelist();
        start_test();
        send_frame(8'hB4, even_parity(8'hB4));
        wait_cycles(20);
        expect_level("cmd_blocked for b4", cmd_blocked, 1'b0);
        send_frame(8'hC2, even_parity(8'hC2));
        wait_cycles(20);
        expect_level("cmd_blocked for c2", cmd_blocked, 1'b0);
        send_frame(8'h55, even_parity(8'h55));
        wait_cycles(20);
        expect_level("cmd_blocked for 55", cmd_blocked, 1'b1);
        // 55 again, this time as a data byte
        send_start();
        send_unit(8'hA0, even_parity(8'hA0));
        expect_level("cmd_blocked for a0", cmd_blocked, 1'b0);
        send_unit(8'h55, even_parity(8'h55));
        send_stop();
        wait_cycles(20);
        expect_level("cmd_blocked after data 55", cmd_blocked, 1'b0);
        expect_level("parity_error", parity_error, 1'b0);
        expected.push_back(8'hB4);
        expected.push_back(8'hC2);
        expected.push_back(8'h55);
        expected.push_back(8'hA0);
        expected.push_back(8'h55);
        compare_captured();
        finish_test("whitelist");
    endtask

    task automatic test_abort();
        logic  saved_par;
        logic  saved_blk;
        byte_t partial;
        start_test();
        saved_par = parity_error;
        saved_blk = cmd_blocked;
        partial = 8'hB4;
        send_start();
        for (int i = 7; i >= 3; i--) begin
            send_bit(partial[i]);
        end
        send_stop();
        wait_cycles(20);
        compare_captured();
        expect_level("parity_error after abort", parity_error, saved_par);
        expect_level("cmd_blocked after abort", cmd_blocked, saved_blk);
        send_frame(8'hC2, even_parity(8'hC2));
        wait_cycles(20);
        expected.push_back(8'hC2);
        compare_captured();
        expect_level("parity_error", parity_error, 1'b0);
        expect_level("cmd_blocked", cmd_blocked, 1'b0);
        finish_test("abort");
    endtask

    task automatic test_repeated_start();
        start_test();
        send_start();
        send_unit(8'h55, even_parity(8'h55));
        expect_level("cmd_blocked for 55", cmd_blocked, 1'b1);
        send_start();
        send_unit(8'hA0, even_parity(8'hA0));
        send_stop();
        wait_cycles(20);
        expected.push_back(8'h55);
        expected.push_back(8'hA0);
        compare_captured();
        expect_level("cmd_blocked", cmd_blocked, 1'b0);
        finish_test("repeated start");
    endtask

    task automatic test_random_stream();
        logic [7:0] data;
        logic [7:0] flip_bits;
        logic       flip;
        logic       blk_exp;
        start_test();
        send_start();
        for (int i = 0; i < 30; i++) begin
            take_bits(8, data);
            take_bits(1, flip_bits);
            flip = flip_bits[0];
            send_unit(data, even_parity(data) ^ flip);
            expected.push_back(data);
            expect_level($sformatf("parity_error after unit %0d", i), parity_error, flip);
            if (i == 0) begin
                blk_exp = !(data == 8'hA0 || data == 8'hB4 || data == 8'hC2);
                expect_level("cmd_blocked for random command", cmd_blocked, blk_exp);
            end
        end
        send_stop();
        wait_cycles(20);
        compare_captured();
        finish_test("random stream");
    endtask

    initial begin
        rst_sync_n   = 1'b0;
        scl          = 1'b1;
        sda          = 1'b1;
        lfsr_state   = 32'h3c28;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_sync_n = 1'b1;
        wait_cycles(4);
        test_good_parity();
        test_bad_parity();
        test_whitelist();
        test_abort();
        test_repeated_start();
        test_random_stream();
        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/i2c_guard_top.sv ====
// top level of the passive i2c guard: sampler, counter, fsm and checkers
`default_nettype none

module i2c_guard_top #(
    parameter bit parity_en     = 1'b1,
    parameter bit cmd_whitelist = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_sync_n,
    input  logic                 scl,
    input  logic                 sda,
    output logic                 byte_strobe,
    output i2c_guard_pkg::byte_t rx_byte,
    output logic                 parity_error,
    output logic                 cmd_blocked
);

    logic scl_rise;
    logic sda_bit;
    logic start_det;
    logic stop_det;
    logic cnt_clear;
    logic bit_take;
    logic shift_en;
    logic cmd_phase;
    logic byte_done;
    logic parity_take;

    i2c_line_sampler u_i2c_line_sampler (
        .clk        (clk),
        .rst_sync_n (rst_sync_n),
        .scl        (scl),
        .sda        (sda),
        .scl_rise   (scl_rise),
        .sda_bit    (sda_bit),
        .start_det  (start_det),
        .stop_det   (stop_det)
    );

    // unit position stays inside the counter
    i2c_bit_counter u_i2c_bit_counter (
        .clk         (clk),
        .rst_sync_n  (rst_sync_n),
        .cnt_clear   (cnt_clear),
        .bit_take    (bit_take),
        .bit_idx     (),
        .byte_done   (byte_done),
        .parity_take (parity_take)
    );

    i2c_frame_fsm u_i2c_frame_fsm (
        .clk         (clk),
        .rst_sync_n  (rst_sync_n),
        .scl_rise    (scl_rise),
        .start_det   (start_det),
        .stop_det    (stop_det),
        .byte_done   (byte_done),
        .parity_take (parity_take),
        .cnt_clear   (cnt_clear),
        .bit_take    (bit_take),
        .shift_en    (shift_en),
        .cmd_phase   (cmd_phase)
    );

    i2c_byte_shifter u_i2c_byte_shifter (
        .clk         (clk),
        .rst_sync_n  (rst_sync_n),
        .shift_en    (shift_en),
        .sda_bit     (sda_bit),
        .byte_done   (byte_done),
        .rx_byte     (rx_byte),
        .byte_strobe (byte_strobe)
    );

    i2c_parity_check #(
        .parity_en (parity_en)
    ) u_i2c_parity_check (
        .clk          (clk),
        .rst_sync_n   (rst_sync_n),
        .byte_strobe  (byte_strobe),
        .rx_byte      (rx_byte),
        .parity_take  (parity_take),
        .sda_bit      (sda_bit),
        .parity_error (parity_error)
    );

    i2c_cmd_filter #(
        .cmd_whitelist (cmd_whitelist)
    ) u_i2c_cmd_filter (
        .clk         (clk),
        .rst_sync_n  (rst_sync_n),
        .byte_strobe (byte_strobe),
        .rx_byte     (rx_byte),
        .cmd_phase   (cmd_phase),
        .cmd_blocked (cmd_blocked)
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_cmd_filter.sv ====
// two-stage whitelist compare of the command byte after START
`default_nettype none

module i2c_cmd_filter #(
    parameter bit cmd_whitelist = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_sync_n,
    input  logic                 byte_strobe,
    input  i2c_guard_pkg::byte_t rx_byte,
    input  logic                 cmd_phase,
    output logic                 cmd_blocked
);

    import i2c_guard_pkg::*;

    logic match_a0;
    logic match_b4;
    logic match_c2;
    logic cmd_valid;

    // stage 1: one match flag per allowed code
    always_ff @(posedge clk) begin
        if (byte_strobe && cmd_phase) begin
            match_a0 <= (rx_byte == cmd_allow_a0);
            match_b4 <= (rx_byte == cmd_allow_b4);
            match_c2 <= (rx_byte == cmd_allow_c2);
        end
    end

    // stage 2, data bytes never reach here
    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            cmd_valid   <= 1'b0;
            cmd_blocked <= 1'b0;
        end else begin
            cmd_valid <= byte_strobe && cmd_phase;
            if (cmd_valid) begin
                cmd_blocked <= cmd_whitelist && !(match_a0 || match_b4 || match_c2);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/i2c_parity_check.sv ====
// two-stage even parity check of each byte against its ninth bit
`default_nettype none

module i2c_parity_check #(
    parameter bit parity_en = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_sync_n,
    input  logic                 byte_strobe,
    input  i2c_guard_pkg::byte_t rx_byte,
    input  logic                 parity_take,
    input  logic                 sda_bit,
    output logic                 parity_error
);

    logic nib_lo_par;
    logic nib_hi_par;
    logic calc_par;
    logic rx_par;
    logic chk_valid;

    // nibble parities held until the ninth bit shows up
    always_ff @(posedge clk) begin
        if (byte_strobe) begin
            nib_lo_par <= ^rx_byte[3:0];
            nib_hi_par <= ^rx_byte[7:4];
        end
        if (parity_take) begin
            calc_par <= nib_lo_par ^ nib_hi_par;
            rx_par   <= sda_bit;
        end
    end

    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            chk_valid    <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            chk_valid <= parity_take;
            if (chk_valid) begin
                // constant low when checking is off
                parity_error <= parity_en && (calc_par != rx_par);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/i2c_byte_shifter.sv ====
// msb-first shift register publishing each completed byte
`default_nettype none

module i2c_byte_shifter (
    input  logic                 clk,
    input  logic                 rst_sync_n,
    input  logic                 shift_en,
    input  logic                 sda_bit,
    input  logic                 byte_done,
    output i2c_guard_pkg::byte_t rx_byte,
    output logic                 byte_strobe
);

    import i2c_guard_pkg::*;

    byte_t shift_reg;
    byte_t shift_nxt;

    // byte_done lands on the eighth shift, so take the bit directly
    assign shift_nxt = {shift_reg[6:0], sda_bit};

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_reg <= shift_nxt;
        end
        if (byte_done) begin
            rx_byte <= shift_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            byte_strobe <= 1'b0;
        end else begin
            byte_strobe <= byte_done;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/i2c_frame_fsm.sv ====
// frame state machine steering counter, shifter and command filter
`default_nettype none

module i2c_frame_fsm (
    input  logic clk,
    input  logic rst_sync_n,
    input  logic scl_rise,
    input  logic start_det,
    input  logic stop_det,
    input  logic byte_done,
    input  logic parity_take,
    output logic cnt_clear,
    output logic bit_take,
    output logic shift_en,
    output logic cmd_phase
);

    import i2c_guard_pkg::*;

    frame_state_t state;
    frame_state_t state_nxt;
    logic         frame_open;
    logic         byte_done_d;

    always_comb begin
        state_nxt = state;
        if (stop_det) begin
            state_nxt = st_idle;
        end else if (start_det) begin
            // also covers a repeated START
            state_nxt = st_command;
        end else begin
            case (state)
                st_idle: begin
                    // clocking without a START seen, sit out this transfer
                    if (scl_rise) begin
                        state_nxt = st_wait_stop;
                    end
                end
                st_command: begin
                    if (parity_take) begin
                        state_nxt = st_data;
                    end
                end
                st_data: begin
                    state_nxt = st_data;
                end
                st_wait_stop: begin
                    state_nxt = st_wait_stop;
                end
                default: begin
                    state_nxt = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            state       <= st_idle;
            byte_done_d <= 1'b0;
            cmd_phase   <= 1'b0;
        end else begin
            state       <= state_nxt;
            byte_done_d <= byte_done;
            // held from START through the command byte strobe
            if (stop_det) begin
                cmd_phase <= 1'b0;
            end else if (start_det) begin
                cmd_phase <= 1'b1;
            end else if (byte_done_d) begin
                cmd_phase <= 1'b0;
            end
        end
    end

    assign frame_open = (state == st_command) || (state == st_data);
    assign cnt_clear  = start_det || stop_det;
    assign bit_take   = scl_rise && frame_open;
    // ninth bit stays out of the shifter
    assign shift_en   = bit_take && !parity_take;

    a_cmd_phase_state: assert property (
        @(posedge clk) disable iff (!rst_sync_n)
        cmd_phase |-> (state == st_command)
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_bit_counter.sv ====
// bit position counter for nine-bit units with byte and parity markers
`default_nettype none

module i2c_bit_counter (
    input  logic                    clk,
    input  logic                    rst_sync_n,
    input  logic                    cnt_clear,
    input  logic                    bit_take,
    output i2c_guard_pkg::bit_idx_t bit_idx,
    output logic                    byte_done,
    output logic                    parity_take
);

    import i2c_guard_pkg::*;

    // markers follow the take in the same cycle
    assign byte_done   = bit_take && (bit_idx == last_data_idx);
    assign parity_take = bit_take && (bit_idx == parity_idx);

    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            bit_idx <= '0;
        end else if (cnt_clear) begin
            // START or STOP drops a partial unit
            bit_idx <= '0;
        end else if (bit_take) begin
            if (bit_idx == parity_idx) begin
                bit_idx <= '0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end
    end

    // a take lost under a clear would shift the whole unit
    a_take_not_cleared: assert property (
        @(posedge clk) disable iff (!rst_sync_n)
        bit_take |-> !cnt_clear
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_line_sampler.sv ====
// scl/sda synchronizer with scl rising edge, START and STOP detection
`default_nettype none

module i2c_line_sampler (
    input  logic clk,
    input  logic rst_sync_n,
    input  logic scl,
    input  logic sda,
    output logic scl_rise,
    output logic sda_bit,
    output logic start_det,
    output logic stop_det
);

    logic scl_meta;
    logic scl_sync;
    logic scl_prev;
    logic sda_meta;
    logic sda_sync;
    logic sda_prev;

    // two-flop synchronizers start at the idle bus level
    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            scl_meta <= 1'b1;
            scl_sync <= 1'b1;
            sda_meta <= 1'b1;
            sda_sync <= 1'b1;
        end else begin
            scl_meta <= scl;
            scl_sync <= scl_meta;
            sda_meta <= sda;
            sda_sync <= sda_meta;
        end
    end

    // previous levels and registered line events
    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            scl_prev  <= 1'b1;
            sda_prev  <= 1'b1;
            scl_rise  <= 1'b0;
            sda_bit   <= 1'b1;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end else begin
            scl_prev  <= scl_sync;
            sda_prev  <= sda_sync;
            scl_rise  <= scl_sync && !scl_prev;
            sda_bit   <= sda_sync;
            // sda moving while scl stays high
            start_det <= scl_sync && scl_prev && sda_prev && !sda_sync;
            stop_det  <= scl_sync && scl_prev && !sda_prev && sda_sync;
        end
    end

    // both lines moving in one sample would hide a START or STOP
    a_lines_apart: assert property (
        @(posedge clk) disable iff (!rst_sync_n)
        (scl_sync != scl_prev) |-> (sda_sync == sda_prev)
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_guard_pkg.sv ====
// shared widths, frame state encoding and command whitelist codes
`default_nettype none

package i2c_guard_pkg;

    // one bus data byte
    typedef logic [7:0] byte_t;

    // position inside a nine-bit unit, 0 to 8
    typedef logic [3:0] bit_idx_t;

    // frame tracking states
    typedef enum logic [1:0] {
        st_idle,
        st_command,
        st_data,
        st_wait_stop
    } frame_state_t;

    // last data position and parity position within a unit
    localparam bit_idx_t last_data_idx = 4'd7;
    localparam bit_idx_t parity_idx    = 4'd8;

    // command bytes allowed right after a START
    localparam byte_t cmd_allow_a0 = 8'hA0;
    localparam byte_t cmd_allow_b4 = 8'hB4;
    localparam byte_t cmd_allow_c2 = 8'hC2;

endpackage

`default_nettype wire
